//--- Makefile
SIM  := obj_dir/Vtb_rv_core
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rv_core -f src.f

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Testbench failed" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert
    import rv_core_pkg::*;
#(
    parameter int XLEN = rv_core_pkg::XLEN
) (
    input  wire logic            inst_selfdefine,
    input  wire logic            reset,
    input  wire logic            if_valid,
    input  wire logic            if_ready,
    input  wire logic [XLEN-1:0] if_addr,
    input  wire inst_t           if_data,
    input  wire logic            commit_valid,
    input  wire logic [XLEN-1:0] commit_pc,
    input  wire inst_t           commit_inst,
    input  wire logic            commit_wen,
    input  wire reg_idx_t        commit_rd
);

    int unsigned failures = 0;
    logic        writing_op;

    // opcodes that may write rd
    assign writing_op = commit_inst[6:0] inside {op_reg, op_imm, op_lui, op_jal};

    held_request: assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && !if_ready |=> if_valid && $stable(if_addr))
    else begin
        $error("fetch request dropped or moved before it was accepted");
        failures++;
    end

    commit_after_fetch: assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && if_ready |=> commit_valid && !if_valid
            && commit_inst == $past(if_data) && commit_pc == $past(if_addr))
    else begin
        $error("transfer not followed by a matching commit");
        failures++;
    end

    commit_needs_fetch: assert property (@(posedge inst_selfdefine) disable iff (reset)
        commit_valid |-> $past(if_valid && if_ready))
    else begin
        $error("commit without a preceding transfer");
        failures++;
    end

    single_commit: assert property (@(posedge inst_selfdefine) disable iff (reset)
        commit_valid |=> !commit_valid && if_valid)
    else begin
        $error("commit pulse too long or fetch not resumed");
        failures++;
    end

    no_x0_write: assert property (@(posedge inst_selfdefine) disable iff (reset)
        commit_valid && commit_rd == 5'd0 |-> !commit_wen)
    else begin
        $error("write to x0 committed");
        failures++;
    end

    no_write_op: assert property (@(posedge inst_selfdefine) disable iff (reset)
        commit_valid && !writing_op |-> !commit_wen)
    else begin
        $error("branch or unknown opcode wrote a register");
        failures++;
    end

endmodule

bind rv_core rv_core_assert #(
    .XLEN (XLEN)
) u_assert (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .if_valid        (if_valid),
    .if_ready        (if_ready),
    .if_addr         (if_addr),
    .if_data         (if_data),
    .commit_valid    (commit_valid),
    .commit_pc       (commit_pc),
    .commit_inst     (commit_inst),
    .commit_wen      (commit_wen),
    .commit_rd       (commit_rd)
);

`default_nettype wire

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int    CLK_PERIOD  = 100;
    localparam int    PROG_LEN    = 40;
    localparam int    NUM_TESTS   = 6;
    localparam addr_t RESET_PC    = 64'h8000_0000;
    // at most six cycles per instruction, with margin
    localparam int    WATCHDOG_NS = PROG_LEN * 6 * CLK_PERIOD * 2;

    logic        inst_selfdefine;
    logic        reset;
    logic        if_ready;
    inst_t       if_data;
    logic        if_valid;
    addr_t       if_addr;
    logic        commit_valid;
    addr_t       commit_pc;
    inst_t       commit_inst;
    logic        commit_wen;
    reg_idx_t    commit_rd;
    xword_t      commit_data;

    inst_t       imem [0:PROG_LEN-1];
    xword_t      model_regs [0:31];
    addr_t       exp_pc;
    int          errors;
    logic [2:0]  cur_test;
    int          loop_hits;
    int          test_base;
    int          test_last [0:NUM_TESTS-1];
    string       test_name [0:NUM_TESTS-1];
    logic        run_done;
    logic        armed;
    int unsigned delay_left;
    logic [5:0]  fetch_idx;

    rv_core #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) uut (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data         (if_data),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_inst     (commit_inst),
        .commit_wen      (commit_wen),
        .commit_rd       (commit_rd),
        .commit_data     (commit_data)
    );

    always #(CLK_PERIOD / 2) inst_selfdefine = ~inst_selfdefine;

    function automatic inst_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_reg};
    endfunction

    function automatic inst_t i_type(int f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op_imm};
    endfunction

    function automatic inst_t lui_word(int rd, int imm20);
        return {20'(imm20), 5'(rd), op_lui};
    endfunction

    function automatic inst_t jal_word(int rd, int offset);
        logic [20:0] o;
        o = 21'(offset);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), op_jal};
    endfunction

    function automatic inst_t branch_word(int f3, int rs1, int rs2, int offset);
        logic [12:0] o;
        o = 13'(offset);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], op_branch};
    endfunction

    // sign-extend the low bits of v
    function automatic xword_t sext(logic [31:0] v, int bits);
        xword_t r;
        r = xword_t'(v) << (64 - bits);
        return xword_t'($signed(r) >>> (64 - bits));
    endfunction

    function automatic int total_failures();
        return errors + int'(uut.u_assert.failures);
    endfunction

    task automatic check_value(string what, xword_t got, xword_t want);
        assert (got === want)
        else begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic load_program();
        imem[0]  = i_type(0, 1, 0, 5);
        imem[1]  = i_type(0, 2, 0, -3);
        imem[2]  = r_type(0, 0, 3, 1, 2);
        imem[3]  = r_type(32, 0, 4, 1, 2);
        imem[4]  = r_type(0, 7, 5, 1, 2);
        imem[5]  = r_type(0, 6, 6, 1, 2);
        imem[6]  = r_type(0, 4, 7, 1, 2);
        imem[7]  = r_type(0, 2, 8, 2, 1);
        imem[8]  = r_type(0, 2, 9, 1, 2);
        imem[9]  = lui_word(10, 32'h80001);
        imem[10] = i_type(0, 11, 10, -1);
        imem[11] = r_type(32, 0, 12, 0, 10);
        imem[12] = r_type(0, 0, 13, 12, 11);
        // writes to x0, then reads of it
        imem[13] = i_type(0, 0, 0, 7);
        imem[14] = r_type(0, 0, 0, 1, 1);
        imem[15] = lui_word(0, 32'h12345);
        imem[16] = r_type(0, 0, 14, 0, 1);
        imem[17] = r_type(32, 0, 15, 0, 0);
        imem[18] = i_type(0, 16, 0, 5);
        imem[19] = branch_word(0, 1, 16, 8);
        imem[20] = i_type(0, 17, 0, 99);
        imem[21] = branch_word(1, 1, 16, 8);
        imem[22] = i_type(0, 18, 0, 1);
        imem[23] = branch_word(0, 1, 2, 8);
        imem[24] = i_type(0, 19, 0, 2);
        imem[25] = branch_word(1, 1, 2, 8);
        imem[26] = i_type(0, 20, 0, 3);
        imem[27] = r_type(0, 0, 21, 19, 18);
        imem[28] = jal_word(22, 12);
        imem[29] = i_type(0, 23, 0, 1);
        imem[30] = i_type(0, 24, 0, 1);
        imem[31] = r_type(0, 0, 25, 22, 0);
        imem[32] = jal_word(0, 8);
        imem[33] = i_type(0, 26, 0, 1);
        imem[34] = i_type(0, 27, 0, 9);
        // custom-0 opcode and xori both retire without a write
        imem[35] = 32'h0000_028b;
        imem[36] = i_type(4, 6, 1, 1);
        imem[37] = r_type(0, 0, 28, 5, 6);
        imem[38] = r_type(0, 2, 29, 10, 0);
        imem[39] = jal_word(0, 0);
    endtask

    task automatic process_commit();
        inst_t      w;
        reg_idx_t   rd;
        logic [2:0] f3;
        xword_t     a;
        xword_t     b;
        xword_t     res;
        addr_t      next_pc;
        logic       wen;
        logic [5:0] word_idx;
        w       = commit_inst;
        rd      = w[11:7];
        f3      = w[14:12];
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        res     = '0;
        wen     = 1'b0;
        next_pc = exp_pc + 64'd4;
        case (w[6:0])
            op_reg: begin
                wen = 1'b1;
                case ({w[31:25], f3})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    10'b0000000_100: res = a ^ b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_111: res = a & b;
                    default: wen = 1'b0;
                endcase
            end
            op_imm: begin
                wen = (f3 == 3'b000);
                res = a + sext({20'b0, w[31:20]}, 12);
            end
            op_lui: begin
                wen = 1'b1;
                res = sext({w[31:12], 12'b0}, 32);
            end
            op_jal: begin
                wen     = 1'b1;
                res     = exp_pc + 64'd4;
                next_pc = exp_pc + sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                check_value("jal link data", commit_data, exp_pc + 64'd4);
            end
            op_branch: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    next_pc = exp_pc + sext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                end
            end
            default: wen = 1'b0;
        endcase
        if (rd == 5'd0) begin
            wen = 1'b0;
        end
        check_value("commit_pc", commit_pc, exp_pc);
        check_value("commit_wen", xword_t'(commit_wen), xword_t'(wen));
        if (wen) begin
            check_value("commit_rd", xword_t'(commit_rd), xword_t'(rd));
            check_value("commit_data", commit_data, res);
            model_regs[rd] = res;
        end

        word_idx = 6'((exp_pc - RESET_PC) >> 2);
        if (cur_test < 3'(NUM_TESTS) && int'(word_idx) == test_last[cur_test]) begin
            if (int'(word_idx) == PROG_LEN - 1) begin
                loop_hits++;
            end
            // the self-loop counts as done on its second pass
            if (int'(word_idx) != PROG_LEN - 1 || loop_hits == 2) begin
                $display("test %s finished, %0d failures", test_name[cur_test],
                         total_failures() - test_base);
                test_base = total_failures();
                cur_test  = cur_test + 3'd1;
                run_done  = (cur_test == 3'(NUM_TESTS));
            end
        end
        exp_pc = next_pc;
    endtask

    // instruction memory responder, waits 0 to 3 cycles per request
    always @(posedge inst_selfdefine) begin
        #1;
        if (reset || !if_valid) begin
            if_ready = 1'b0;
            armed    = 1'b0;
        end else begin
            if (!armed) begin
                delay_left = $urandom % 4;
                armed      = 1'b1;
            end
            if (delay_left == 0) begin
                if_ready = 1'b1;
                armed    = 1'b0;
                if ((if_addr - RESET_PC) < xword_t'(4 * PROG_LEN)) begin
                    fetch_idx = 6'((if_addr - RESET_PC) >> 2);
                    if_data   = imem[fetch_idx];
                end else begin
                    errors++;
                    $display("Fetch address %h lies outside the program", if_addr);
                    if_data = '0;
                end
            end else begin
                if_ready = 1'b0;
                delay_left--;
            end
        end
    end

    // outputs are settled by mid-cycle
    always @(negedge inst_selfdefine) begin
        if (!reset && if_valid) begin
            check_value("if_addr", if_addr, exp_pc);
        end
        if (!reset && commit_valid) begin
            process_commit();
        end
    end

    initial begin
        void'($urandom(32'he561));
        inst_selfdefine = 1'b0;
        reset           = 1'b1;
        if_ready        = 1'b0;
        if_data         = '0;
        errors          = 0;
        cur_test        = 3'd0;
        loop_hits       = 0;
        test_base       = 0;
        run_done        = 1'b0;
        armed           = 1'b0;
        delay_left      = 0;
        fetch_idx       = '0;
        exp_pc          = RESET_PC;
        model_regs      = '{default: '0};
        load_program();
        test_name[0] = "arith";
        test_last[0] = 12;
        test_name[1] = "x0_writes";
        test_last[1] = 17;
        test_name[2] = "branches";
        test_last[2] = 27;
        test_name[3] = "jumps";
        test_last[3] = 34;
        test_name[4] = "no_ops";
        test_last[4] = 38;
        test_name[5] = "self_loop";
        test_last[5] = 39;

        repeat (4) @(posedge inst_selfdefine);
        #1;
        reset = 1'b0;

        wait (run_done);
        @(posedge inst_selfdefine);
        $display("%0d tests finished, %0d value errors, %0d assertion failures",
                 cur_test, errors, uut.u_assert.failures);
        if (total_failures() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog against a stalled core
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/rv_core_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/inst_decoder.sv
verilog/core_control.sv
verilog/rv_core.sv
sim/rv_core_assert.sv
sim/tb_rv_core.sv

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv_core_pkg::*;
#(
    parameter int XLEN = rv_core_pkg::XLEN
) (
    input  wire alu_op_e         alu_op,
    input  wire logic            alu_src_pc,
    input  wire logic            alu_src_imm,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [XLEN-1:0] rs1_data,
    input  wire logic [XLEN-1:0] rs2_data,
    input  wire logic [XLEN-1:0] imm,
    output logic [XLEN-1:0]      alu_result,
    output logic                 alu_equal
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            less_signed;

    // operand select
    assign op_a = alu_src_pc  ? pc  : rs1_data;
    assign op_b = alu_src_imm ? imm : rs2_data;

    assign less_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (alu_op)
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = {{(XLEN-1){1'b0}}, less_signed};
            default: alu_result = op_a + op_b;
        endcase
    end

    // branch compare always on the register values
    assign alu_equal = (rs1_data == rs2_data);

endmodule

`default_nettype wire

//--- verilog/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control
    import rv_core_pkg::*;
#(
    parameter int              XLEN     = rv_core_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_PC = 'h8000_0000
) (
    input  wire logic            inst_selfdefine,
    input  wire logic            reset,

    input  wire logic            if_ready,
    input  wire inst_t           if_data,

    input  wire logic [XLEN-1:0] alu_result,
    input  wire logic            alu_equal,
    input  wire reg_idx_t        rd_index,
    input  wire logic            rd_en,
    input  wire logic [XLEN-1:0] imm,
    input  wire wb_sel_e         wb_sel,
    input  wire logic            is_branch,
    input  wire logic            branch_ne,
    input  wire logic            is_jal,

    output logic                 if_valid,
    output logic [XLEN-1:0]      if_addr,
    output inst_t                inst,
    output logic [XLEN-1:0]      pc,

    output logic                 wr_en,
    output reg_idx_t             wr_index,
    output logic [XLEN-1:0]      wr_data,

    output logic                 commit_valid,
    output logic [XLEN-1:0]      commit_pc,
    output inst_t                commit_inst,
    output logic                 commit_wen,
    output reg_idx_t             commit_rd,
    output logic [XLEN-1:0]      commit_data
);

    core_state_e       state;
    logic              if_fire;
    logic              take_target;
    logic [XLEN-1:0]   pc_plus4;
    logic [XLEN-1:0]   next_pc;

    assign if_fire  = if_valid && if_ready;
    assign pc_plus4 = pc + XLEN'(4);

    // ALU adds pc and imm for jal and branches, so its result is the target
    assign take_target = is_jal || (is_branch && (alu_equal ^ branch_ne));
    assign next_pc     = take_target ? alu_result : pc_plus4;

    // if_valid is registered so it stays low through reset
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state    <= st_fetch;
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if_valid <= !if_fire;
                    if (if_fire) begin
                        state <= st_exec;
                    end
                end
                default: begin
                    state    <= st_fetch;
                    pc       <= next_pc;
                    if_valid <= 1'b1;
                end
            endcase
        end
    end

    // instruction register
    always_ff @(posedge inst_selfdefine) begin
        if (if_fire) begin
            inst <= if_data;
        end
    end

    assign if_addr = pc;

    // writeback
    always_comb begin
        case (wb_sel)
            wb_imm:  wr_data = imm;
            wb_link: wr_data = pc_plus4;
            default: wr_data = alu_result;
        endcase
    end

    assign wr_en    = (state == st_exec) && rd_en;
    assign wr_index = rd_index;

    // trace mirrors the exec cycle
    assign commit_valid = (state == st_exec);
    assign commit_pc    = pc;
    assign commit_inst  = inst;
    assign commit_wen   = wr_en;
    assign commit_rd    = wr_index;
    assign commit_data  = wr_data;

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_core_pkg::*;
#(
    parameter int XLEN = rv_core_pkg::XLEN
) (
    input  wire inst_t      inst,

    output reg_idx_t        rs1_index,
    output reg_idx_t        rs2_index,
    output reg_idx_t        rd_index,
    output logic            rd_en,
    output logic [XLEN-1:0] imm,
    output alu_op_e         alu_op,
    output logic            alu_src_pc,
    output logic            alu_src_imm,
    output wb_sel_e         wb_sel,
    output logic            is_branch,
    output logic            branch_ne,
    output logic            is_jal
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_j;
    logic              f7_zero;
    logic              f7_alt;
    logic              writes_rd;

    assign opcode    = inst[6:0];
    assign rd_index  = inst[11:7];
    assign funct3    = inst[14:12];
    assign rs1_index = inst[19:15];
    assign rs2_index = inst[24:20];
    assign funct7    = inst[31:25];

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // sign-extended immediates
    assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        writes_rd   = 1'b0;
        imm         = imm_i;
        alu_op      = alu_add;
        alu_src_pc  = 1'b0;
        alu_src_imm = 1'b0;
        wb_sel      = wb_alu;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        is_jal      = 1'b0;
        case (opcode)
            op_reg: begin
                case (funct3)
                    3'b000: begin
                        alu_op    = f7_alt ? alu_sub : alu_add;
                        writes_rd = f7_zero || f7_alt;
                    end
                    3'b010: begin
                        alu_op    = alu_slt;
                        writes_rd = f7_zero;
                    end
                    3'b100: begin
                        alu_op    = alu_xor;
                        writes_rd = f7_zero;
                    end
                    3'b110: begin
                        alu_op    = alu_or;
                        writes_rd = f7_zero;
                    end
                    3'b111: begin
                        alu_op    = alu_and;
                        writes_rd = f7_zero;
                    end
                    default: writes_rd = 1'b0;
                endcase
            end
            op_imm: begin
                // only addi, the rest retire as no-ops
                alu_src_imm = 1'b1;
                writes_rd   = (funct3 == 3'b000);
            end
            op_lui: begin
                imm       = imm_u;
                wb_sel    = wb_imm;
                writes_rd = 1'b1;
            end
            op_jal: begin
                imm         = imm_j;
                alu_src_pc  = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = wb_link;
                is_jal      = 1'b1;
                writes_rd   = 1'b1;
            end
            op_branch: begin
                imm         = imm_b;
                alu_src_pc  = 1'b1;
                alu_src_imm = 1'b1;
                // beq and bne only
                is_branch   = (funct3[2:1] == 2'b00);
                branch_ne   = funct3[0];
            end
            default: writes_rd = 1'b0;
        endcase
    end

    // x0 is never written
    assign rd_en = writes_rd && (rd_index != 5'd0);

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import rv_core_pkg::*;
#(
    parameter int XLEN = rv_core_pkg::XLEN
) (
    input  wire logic            inst_selfdefine,
    input  wire logic            reset,
    input  wire reg_idx_t        rs1_index,
    input  wire reg_idx_t        rs2_index,
    input  wire logic            wr_en,
    input  wire reg_idx_t        wr_index,
    input  wire logic [XLEN-1:0] wr_data,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data
);

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_index] <= wr_data;
        end
    end

    assign rs1_data = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == 5'd0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
#(
    parameter int              XLEN     = rv_core_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_PC = 'h8000_0000
) (
    input  wire logic            inst_selfdefine,
    input  wire logic            reset,

    // instruction fetch port
    input  wire logic            if_ready,
    input  wire inst_t           if_data,
    output logic                 if_valid,
    output logic [XLEN-1:0]      if_addr,

    // retired instruction trace
    output logic                 commit_valid,
    output logic [XLEN-1:0]      commit_pc,
    output inst_t                commit_inst,
    output logic                 commit_wen,
    output reg_idx_t             commit_rd,
    output logic [XLEN-1:0]      commit_data
);

    inst_t             inst;
    logic [XLEN-1:0]   pc;

    reg_idx_t          rs1_index;
    reg_idx_t          rs2_index;
    reg_idx_t          rd_index;
    logic              rd_en;
    logic [XLEN-1:0]   imm;
    alu_op_e           alu_op;
    logic              alu_src_pc;
    logic              alu_src_imm;
    wb_sel_e           wb_sel;
    logic              is_branch;
    logic              branch_ne;
    logic              is_jal;

    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   alu_result;
    logic              alu_equal;

    logic              wr_en;
    reg_idx_t          wr_index;
    logic [XLEN-1:0]   wr_data;

    core_control #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) u_control (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data         (if_data),
        .alu_result      (alu_result),
        .alu_equal       (alu_equal),
        .rd_index        (rd_index),
        .rd_en           (rd_en),
        .imm             (imm),
        .wb_sel          (wb_sel),
        .is_branch       (is_branch),
        .branch_ne       (branch_ne),
        .is_jal          (is_jal),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .inst            (inst),
        .pc              (pc),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_data         (wr_data),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_inst     (commit_inst),
        .commit_wen      (commit_wen),
        .commit_rd       (commit_rd),
        .commit_data     (commit_data)
    );

    inst_decoder #(
        .XLEN (XLEN)
    ) u_decoder (
        .inst        (inst),
        .rs1_index   (rs1_index),
        .rs2_index   (rs2_index),
        .rd_index    (rd_index),
        .rd_en       (rd_en),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_src_pc  (alu_src_pc),
        .alu_src_imm (alu_src_imm),
        .wb_sel      (wb_sel),
        .is_branch   (is_branch),
        .branch_ne   (branch_ne),
        .is_jal      (is_jal)
    );

    regfile #(
        .XLEN (XLEN)
    ) u_regfile (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1_index       (rs1_index),
        .rs2_index       (rs2_index),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_data         (wr_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    alu #(
        .XLEN (XLEN)
    ) u_alu (
        .alu_op      (alu_op),
        .alu_src_pc  (alu_src_pc),
        .alu_src_imm (alu_src_imm),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_result  (alu_result),
        .alu_equal   (alu_equal)
    );

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // data width, also the default for the module parameters
    parameter int XLEN = 64;

    typedef logic [31:0]      inst_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [XLEN-1:0]  xword_t;
    typedef logic [XLEN-1:0]  addr_t;

    // major opcodes the core executes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_imm  = 2'd1,
        wb_link = 2'd2
    } wb_sel_e;

    typedef enum logic {
        st_fetch = 1'b0,
        st_exec  = 1'b1
    } core_state_e;

endpackage

`default_nettype wire
